//--- source/rp_pkg.sv
/*
  Shared widths, sample types and the register map of the analog data path.
  All samples are two's complement; the bus moves 16-bit words.
  Register addresses are word addresses; per-channel registers sit at base + channel.
*/
package rp_pkg;

  // channel counts
  localparam int adc_chn_n = 2;
  localparam int pdm_chn_n = 4;

  // sample and calibration types
  typedef logic signed [14-1:0] smp_t;
  typedef logic        [14-1:0] pin_t;
  typedef logic        [14-1:0] dac_t;
  typedef logic signed [16-1:0] gain_t;
  typedef logic signed [14-1:0] offs_t;
  typedef logic        [ 8-1:0] pdm_t;

  // bus words
  typedef logic [ 4-1:0] reg_addr_t;
  typedef logic [16-1:0] reg_data_t;

  // calibration arithmetic
  localparam int    gain_shift = 14;
  localparam gain_t gain_unity = 16'h4000;
  typedef logic signed [$bits(smp_t)+$bits(gain_t)-1:0] prod_t;
  // shifted product plus offset, one bit of headroom
  typedef logic signed [$bits(prod_t)-gain_shift:0] acc_t;
  localparam smp_t smp_max = 14'sh1fff;
  localparam smp_t smp_min = 14'sh2000;

  // pdm period in clock cycles
  localparam int pdm_range = 255;

  //////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////
  localparam reg_addr_t reg_ctrl    = 4'd0;   // bit 0 digital loopback
  localparam reg_addr_t reg_adc_mul = 4'd1;   // 1, 2
  localparam reg_addr_t reg_adc_sum = 4'd3;   // 3, 4
  localparam reg_addr_t reg_dac_mul = 4'd5;   // 5, 6
  localparam reg_addr_t reg_dac_sum = 4'd7;   // 7, 8
  localparam reg_addr_t reg_dac_lvl = 4'd9;   // 9, 10
  localparam reg_addr_t reg_pdm     = 4'd11;  // 11 to 14

endpackage

//--- source/rp_cfg_if.sv
/*
  Static configuration from the register block to the data path and PDM.
  Values change only on bus writes; readers treat them as quasi-static.
*/
`timescale 1ns/1ps

interface rp_cfg_if import rp_pkg::*; ();

  // loopback control
  logic                     digital_loop;
  // adc calibration per channel
  gain_t [adc_chn_n-1:0]    adc_mul;
  offs_t [adc_chn_n-1:0]    adc_sum;
  // dac calibration per channel
  gain_t [adc_chn_n-1:0]    dac_mul;
  offs_t [adc_chn_n-1:0]    dac_sum;
  // constant dac source level
  smp_t  [adc_chn_n-1:0]    dac_lvl;
  // slow analog outputs
  pdm_t  [pdm_chn_n-1:0]    pdm_lvl;

  // register block side
  modport regs_mp (
    output digital_loop, adc_mul, adc_sum, dac_mul, dac_sum, dac_lvl, pdm_lvl
  );

  // data path and pdm side
  modport path_mp (
    input  digital_loop, adc_mul, adc_sum, dac_mul, dac_sum, dac_lvl, pdm_lvl
  );

endinterface

//--- source/rp_regs.sv
/*
  Configuration registers on a single-cycle strobe bus.
  Only one of wen/ren may be high in a cycle; ack follows one cycle later.
  Unmapped writes are dropped but acked, unmapped reads return zero.
*/
`timescale 1ns/1ps

module rp_regs import rp_pkg::*; (
  input  logic         adc_clk,
  input  logic         rst,
  // strobe bus
  input  logic         bus_wen_i,
  input  logic         bus_ren_i,
  input  reg_addr_t    bus_addr_i,
  input  reg_data_t    bus_wdata_i,
  output reg_data_t    bus_rdata_o,
  output logic         bus_ack_o,
  // configuration out
  rp_cfg_if.regs_mp    cfg
);

  reg_data_t rd_mux;

  ////////////////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge rst) begin
    if (rst) begin
      cfg.digital_loop <= 1'b0;
      for (int i = 0; i < adc_chn_n; i++) begin
        cfg.adc_mul[i] <= gain_unity;
        cfg.adc_sum[i] <= '0;
        cfg.dac_mul[i] <= gain_unity;
        cfg.dac_sum[i] <= '0;
        cfg.dac_lvl[i] <= '0;
      end
      for (int i = 0; i < pdm_chn_n; i++) begin
        cfg.pdm_lvl[i] <= '0;
      end
    end else if (bus_wen_i) begin
      if (bus_addr_i == reg_ctrl)
        cfg.digital_loop <= bus_wdata_i[0];
      // narrow fields keep the low bits of the bus word
      for (int i = 0; i < adc_chn_n; i++) begin
        if (bus_addr_i == reg_addr_t'(reg_adc_mul + i))
          cfg.adc_mul[i] <= bus_wdata_i;
        if (bus_addr_i == reg_addr_t'(reg_adc_sum + i))
          cfg.adc_sum[i] <= bus_wdata_i[$bits(offs_t)-1:0];
        if (bus_addr_i == reg_addr_t'(reg_dac_mul + i))
          cfg.dac_mul[i] <= bus_wdata_i;
        if (bus_addr_i == reg_addr_t'(reg_dac_sum + i))
          cfg.dac_sum[i] <= bus_wdata_i[$bits(offs_t)-1:0];
        if (bus_addr_i == reg_addr_t'(reg_dac_lvl + i))
          cfg.dac_lvl[i] <= bus_wdata_i[$bits(smp_t)-1:0];
      end
      for (int i = 0; i < pdm_chn_n; i++) begin
        if (bus_addr_i == reg_addr_t'(reg_pdm + i))
          cfg.pdm_lvl[i] <= bus_wdata_i[$bits(pdm_t)-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // read-back
  ////////////////////////////////////////////////////////////////////////

  // signed fields are sign-extended to the bus width
  always_comb begin
    rd_mux = '0;
    if (bus_addr_i == reg_ctrl)
      rd_mux = reg_data_t'(cfg.digital_loop);
    for (int i = 0; i < adc_chn_n; i++) begin
      if (bus_addr_i == reg_addr_t'(reg_adc_mul + i))
        rd_mux = cfg.adc_mul[i];
      if (bus_addr_i == reg_addr_t'(reg_adc_sum + i))
        rd_mux = reg_data_t'($signed(cfg.adc_sum[i]));
      if (bus_addr_i == reg_addr_t'(reg_dac_mul + i))
        rd_mux = cfg.dac_mul[i];
      if (bus_addr_i == reg_addr_t'(reg_dac_sum + i))
        rd_mux = reg_data_t'($signed(cfg.dac_sum[i]));
      if (bus_addr_i == reg_addr_t'(reg_dac_lvl + i))
        rd_mux = reg_data_t'($signed(cfg.dac_lvl[i]));
    end
    for (int i = 0; i < pdm_chn_n; i++) begin
      if (bus_addr_i == reg_addr_t'(reg_pdm + i))
        rd_mux = reg_data_t'(cfg.pdm_lvl[i]);
    end
  end

  // ack and data one cycle after the strobe, data zero otherwise
  always_ff @(posedge adc_clk, posedge rst) begin
    if (rst) begin
      bus_ack_o   <= 1'b0;
      bus_rdata_o <= '0;
    end else begin
      bus_ack_o   <= bus_wen_i | bus_ren_i;
      bus_rdata_o <= bus_ren_i ? rd_mux : '0;
    end
  end

endmodule

//--- source/rp_linear.sv
/*
  Gain/offset calibration, fixed latency of two cycles, one sample per cycle.
  Gain is Q2.14, so 0x4000 is unity; results clip to the 14-bit signed range.
  The offset is taken at stage two and is expected to be static.
*/
`timescale 1ns/1ps

module rp_linear import rp_pkg::*; (
  input  logic  adc_clk,
  input  logic  rst,
  input  smp_t  dat_i,
  input  gain_t mul_i,
  input  offs_t sum_i,
  output smp_t  dat_o
);

  prod_t prod_q;
  acc_t  acc;
  // bits above the sample sign, all equal when no overflow
  logic [$bits(acc_t)-$bits(smp_t):0] acc_top;

  // stage one, full signed product
  always_ff @(posedge adc_clk, posedge rst) begin
    if (rst) prod_q <= '0;
    else     prod_q <= dat_i * mul_i;
  end

  // drop the fraction, add the offset
  always_comb begin
    acc     = acc_t'(prod_q >>> gain_shift) + acc_t'(sum_i);
    acc_top = acc[$bits(acc_t)-1:$bits(smp_t)-1];
  end

  // stage two, saturate into the sample range
  always_ff @(posedge adc_clk, posedge rst) begin
    if (rst) begin
      dat_o <= '0;
    end else if (&acc_top || ~|acc_top) begin
      dat_o <= smp_t'(acc);
    end else begin
      dat_o <= acc[$bits(acc_t)-1] ? smp_min : smp_max;
    end
  end

endmodule

//--- source/rp_pdm.sv
/*
  First-order PDM for the slow analog outputs, one accumulator per channel.
  Level n gives exactly n ones in any 255 consecutive cycles; 255 is always high.
*/
`timescale 1ns/1ps

module rp_pdm import rp_pkg::*; (
  input  logic                 adc_clk,
  input  logic                 rst,
  rp_cfg_if.path_mp            cfg,
  output logic [pdm_chn_n-1:0] pdm_o
);

  // one bit wider than the level, holds acc + level before wrap
  logic [pdm_chn_n-1:0][$bits(pdm_t):0] acc_q;
  logic [pdm_chn_n-1:0][$bits(pdm_t):0] acc_nxt;

  always_comb begin
    for (int i = 0; i < pdm_chn_n; i++) begin
      acc_nxt[i] = acc_q[i] + {1'b0, cfg.pdm_lvl[i]};
    end
  end

  // wrap at the period and emit a one
  always_ff @(posedge adc_clk, posedge rst) begin
    if (rst) begin
      acc_q <= '0;
      pdm_o <= '0;
    end else begin
      for (int i = 0; i < pdm_chn_n; i++) begin
        if (acc_nxt[i] >= ($bits(pdm_t)+1)'(pdm_range)) begin
          acc_q[i] <= acc_nxt[i] - ($bits(pdm_t)+1)'(pdm_range);
          pdm_o[i] <= 1'b1;
        end else begin
          acc_q[i] <= acc_nxt[i];
          pdm_o[i] <= 1'b0;
        end
      end
    end
  end

endmodule

//--- source/rp_analog_top.sv
/*
  Two-channel analog data path on one clock, adc_clk.
  top_rst is asynchronous; the internal reset releases two cycles after it drops.
  adc_dat_o lags adc_pin_i by 3 cycles; dac_dat_o lags a level write by 3 cycles.
  DAC channels leave on parallel ports, not interleaved.
*/
`timescale 1ns/1ps

module rp_analog_top import rp_pkg::*; (
  input  logic                   adc_clk,
  input  logic                   top_rst,
  // adc pins 15..2 per channel
  input  pin_t [adc_chn_n-1:0]   adc_pin_i,
  output smp_t [adc_chn_n-1:0]   adc_dat_o,
  // dac offset-binary words
  output dac_t [adc_chn_n-1:0]   dac_dat_o,
  output logic [pdm_chn_n-1:0]   pdm_o,
  // register bus
  input  logic                   bus_wen_i,
  input  logic                   bus_ren_i,
  input  reg_addr_t              bus_addr_i,
  input  reg_data_t              bus_wdata_i,
  output reg_data_t              bus_rdata_o,
  output logic                   bus_ack_o
);

  logic [1:0]            rst_sync_q;
  logic                  rst;
  smp_t [adc_chn_n-1:0]  adc_raw_q;
  smp_t [adc_chn_n-1:0]  adc_lin_in;
  smp_t [adc_chn_n-1:0]  dac_cal;

  rp_cfg_if cfg ();

  ////////////////////////////////////////////////////////////////////////
  // reset synchronizer
  ////////////////////////////////////////////////////////////////////////

  // assert at once, release on the second edge
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) rst_sync_q <= '1;
    else         rst_sync_q <= {rst_sync_q[0], 1'b0};
  end

  assign rst = rst_sync_q[1];

  // registers and read-back
  rp_regs rp_regs_inst (
    .adc_clk     (adc_clk),
    .rst         (rst),
    .bus_wen_i   (bus_wen_i),
    .bus_ren_i   (bus_ren_i),
    .bus_addr_i  (bus_addr_i),
    .bus_wdata_i (bus_wdata_i),
    .bus_rdata_o (bus_rdata_o),
    .bus_ack_o   (bus_ack_o),
    .cfg         (cfg)
  );

  ////////////////////////////////////////////////////////////////////////
  // adc input, loopback mux, calibration
  ////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < adc_chn_n; i++) begin : g_adc
    // keep sign bit, invert the rest (inverted front end)
    always_ff @(posedge adc_clk, posedge rst) begin
      if (rst) adc_raw_q[i] <= '0;
      else     adc_raw_q[i] <= {adc_pin_i[i][$bits(pin_t)-1], ~adc_pin_i[i][$bits(pin_t)-2:0]};
    end

    // loopback takes the calibrated dac sample
    assign adc_lin_in[i] = cfg.digital_loop ? dac_cal[i] : adc_raw_q[i];

    rp_linear rp_linear_adc_inst (
      .adc_clk (adc_clk),
      .rst     (rst),
      .dat_i   (adc_lin_in[i]),
      .mul_i   (cfg.adc_mul[i]),
      .sum_i   (cfg.adc_sum[i]),
      .dat_o   (adc_dat_o[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////
  // dac calibration and output format
  ////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < adc_chn_n; i++) begin : g_dac
    rp_linear rp_linear_dac_inst (
      .adc_clk (adc_clk),
      .rst     (rst),
      .dat_i   (cfg.dac_lvl[i]),
      .mul_i   (cfg.dac_mul[i]),
      .sum_i   (cfg.dac_sum[i]),
      .dat_o   (dac_cal[i])
    );

    // signed to offset binary with negative slope
    always_ff @(posedge adc_clk, posedge rst) begin
      if (rst) dac_dat_o[i] <= '0;
      else     dac_dat_o[i] <= {dac_cal[i][$bits(smp_t)-1], ~dac_cal[i][$bits(smp_t)-2:0]};
    end
  end

  // slow analog outputs
  rp_pdm rp_pdm_inst (
    .adc_clk (adc_clk),
    .rst     (rst),
    .cfg     (cfg),
    .pdm_o   (pdm_o)
  );

endmodule

//--- bench/rp_asserts.sv
/*
  Port-level properties bound into the analog top, sampled on adc_clk.
  Assumes at most one bus strobe per cycle.
*/
`timescale 1ns/1ps

module rp_asserts import rp_pkg::*; (
  input logic                 adc_clk,
  input logic                 top_rst,
  input logic                 bus_wen_i,
  input logic                 bus_ren_i,
  input logic                 bus_ack_o,
  input logic [pdm_chn_n-1:0] pdm_o,
  input smp_t [adc_chn_n-1:0] adc_dat_o
);

  // failure count, read by the testbench at the end
  int fail_n = 0;

  // ack exactly one cycle after every strobe, never otherwise
  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (top_rst)
    bus_ack_o == $past(bus_wen_i || bus_ren_i))
  else begin
    fail_n++;
    $error("bus ack does not follow the strobe by one cycle");
  end

  // outputs quiet while reset is held
  quiet_in_reset: assert property (@(posedge adc_clk)
    top_rst |-> (pdm_o == '0) && !bus_ack_o)
  else begin
    fail_n++;
    $error("pdm or bus ack active during reset");
  end

  adc_known: assert property (@(posedge adc_clk) disable iff (top_rst)
    !$isunknown(adc_dat_o))
  else begin
    fail_n++;
    $error("unknown bits on adc samples");
  end

endmodule

bind rp_analog_top rp_asserts rp_asserts_inst (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .bus_wen_i (bus_wen_i),
  .bus_ren_i (bus_ren_i),
  .bus_ack_o (bus_ack_o),
  .pdm_o     (pdm_o),
  .adc_dat_o (adc_dat_o)
);

//--- bench/rp_tb.sv
/*
  Trace-driven testbench, one operation per data line of bench/rp_trace.txt.
  Inputs change on the falling clock edge and outputs are read there too.
  A register and PDM sweep against the written values follows the trace.
  The first mismatch, a missing ack or the cycle budget ends the run.
*/
`timescale 1ns/1ps

module rp_tb import rp_pkg::*; ();

  logic                 adc_clk;
  logic                 top_rst;
  pin_t [adc_chn_n-1:0] adc_pin_i;
  smp_t [adc_chn_n-1:0] adc_dat_o;
  dac_t [adc_chn_n-1:0] dac_dat_o;
  logic [pdm_chn_n-1:0] pdm_o;
  logic                 bus_wen_i;
  logic                 bus_ren_i;
  reg_addr_t            bus_addr_i;
  reg_data_t            bus_wdata_i;
  reg_data_t            bus_rdata_o;
  logic                 bus_ack_o;

  // trace columns, one entry per operation
  byte         op_q[$];
  int unsigned arg_q[$];
  int unsigned stim_q[$];
  int unsigned exp_q[$];
  int          cycles = 0;
  int          limit = 600;

  // expected read-back per register address
  reg_data_t   regs_exp [2 ** $bits(reg_addr_t)];

  rp_analog_top rp_analog_top_inst (.*);

  // 4 ns clock
  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;
  end

  // cycle budget, scaled by the trace length
  always @(posedge adc_clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, trace not finished", cycles);
      $display("TEST FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input int unsigned expected,
                             input int unsigned actual);
    assert (actual == expected) else begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  // low bits of the bus word kept, signed fields sign-extended on read
  function automatic reg_data_t expected_readback(input reg_addr_t addr,
                                                  input int unsigned wdata);
    reg_data_t val;
    case (addr)
      reg_ctrl:
        val = reg_data_t'(wdata[0]);
      reg_adc_mul, reg_adc_mul + 1, reg_dac_mul, reg_dac_mul + 1:
        val = reg_data_t'(wdata);
      reg_adc_sum, reg_adc_sum + 1, reg_dac_sum, reg_dac_sum + 1,
      reg_dac_lvl, reg_dac_lvl + 1:
        val = {{2{wdata[13]}}, wdata[13:0]};
      reg_pdm, reg_pdm + 1, reg_pdm + 2, reg_pdm + 3:
        val = reg_data_t'(wdata[7:0]);
      default:
        val = '0;
    endcase
    return val;
  endfunction

  // one-cycle strobe, then wait a few cycles for the ack
  task automatic bus_access(input logic wr, input int unsigned addr,
                            input int unsigned wdata, output reg_data_t rdata);
    int waited = 0;
    bus_wen_i   = wr;
    bus_ren_i   = ~wr;
    bus_addr_i  = reg_addr_t'(addr);
    bus_wdata_i = reg_data_t'(wdata);
    @(negedge adc_clk);
    bus_wen_i = 1'b0;
    bus_ren_i = 1'b0;
    while (!bus_ack_o && waited < 4) begin
      @(negedge adc_clk);
      waited++;
    end
    assert (bus_ack_o) else begin
      $display("no bus ack seen for address %0h", addr);
      $display("TEST FAIL");
      $fatal(1, "bus ack missing");
    end
    rdata = bus_rdata_o;
  endtask

  task automatic load_trace();
    int          fd;
    string       line;
    byte         op;
    int unsigned a;
    int unsigned s;
    int unsigned e;
    fd = $fopen("bench/rp_trace.txt", "r");
    assert (fd != 0) else begin
      $display("cannot open the trace file bench/rp_trace.txt");
      $display("TEST FAIL");
      $fatal(1, "trace file missing");
    end
    // comment lines fail on the hex fields
    while ($fgets(line, fd) > 0) begin
      if ($sscanf(line, "%c %h %h %h", op, a, s, e) == 4) begin
        op_q.push_back(op);
        arg_q.push_back(a);
        stim_q.push_back(s);
        exp_q.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    reg_data_t   rdata;
    int          ones;
    int unsigned pdm_ones [pdm_chn_n];
    string       name;
    top_rst     = 1'b1;
    adc_pin_i   = '0;
    bus_wen_i   = 1'b0;
    bus_ren_i   = 1'b0;
    bus_addr_i  = '0;
    bus_wdata_i = '0;
    load_trace();
    limit = 40 * op_q.size() + 600;
    // multipliers come out of reset at unity, all else at zero
    foreach (regs_exp[a]) begin
      regs_exp[a] = (a inside {reg_adc_mul, reg_adc_mul + 1, reg_dac_mul, reg_dac_mul + 1})
                    ? gain_unity : '0;
    end
    repeat (5) @(negedge adc_clk);
    top_rst = 1'b0;
    // internal reset lifts two edges later
    repeat (3) @(negedge adc_clk);
    foreach (op_q[i]) begin
      name = $sformatf("step %0d (%c)", i + 1, op_q[i]);
      case (op_q[i])
        // read data stays zero on a write
        "W": begin
          bus_access(1'b1, arg_q[i], stim_q[i], rdata);
          check_value(name, 0, rdata);
          regs_exp[reg_addr_t'(arg_q[i])] = expected_readback(reg_addr_t'(arg_q[i]),
                                                              stim_q[i]);
        end
        "R": begin
          bus_access(1'b0, arg_q[i], 0, rdata);
          check_value(name, exp_q[i], rdata);
        end
        // pin word in, calibrated sample three cycles on
        "A": begin
          adc_pin_i[arg_q[i]] = pin_t'(stim_q[i]);
          repeat (3) @(negedge adc_clk);
          check_value(name, exp_q[i], $unsigned(adc_dat_o[arg_q[i]]));
        end
        "D": begin
          repeat (4) @(negedge adc_clk);
          check_value(name, exp_q[i], dac_dat_o[arg_q[i]]);
        end
        // ones over one full pdm period
        "P": begin
          ones = 0;
          repeat (pdm_range) begin
            @(negedge adc_clk);
            ones += pdm_o[arg_q[i]];
          end
          check_value(name, exp_q[i], ones);
        end
        default: begin
          $display("unknown operation in the trace at %s", name);
          $display("TEST FAIL");
          $fatal(1, "bad trace");
        end
      endcase
    end
    // every address against what the trace left in it
    for (int a = 0; a < 2 ** $bits(reg_addr_t); a++) begin
      bus_access(1'b0, a, 0, rdata);
      check_value($sformatf("read-back of address %0h", a), regs_exp[a], rdata);
    end
    // all pdm channels over one shared period
    foreach (pdm_ones[c]) begin
      pdm_ones[c] = 0;
    end
    repeat (pdm_range) begin
      @(negedge adc_clk);
      foreach (pdm_ones[c]) begin
        pdm_ones[c] += pdm_o[c];
      end
    end
    foreach (pdm_ones[c]) begin
      check_value($sformatf("pdm density of channel %0d", c), regs_exp[reg_pdm + c],
                  pdm_ones[c]);
    end
    if (rp_analog_top_inst.rp_asserts_inst.fail_n == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("bound assertions failed %0d times", rp_analog_top_inst.rp_asserts_inst.fail_n);
      $display("TEST FAIL");
      $fatal(1, "assertion failures");
    end
  end

endmodule

//--- bench/rp_trace.txt
# op  addr/channel  stimulus  expected, all hex after the op letter
# ops W write, R read, A adc pin, D dac word, P pdm ones in 255 cycles
R 0 0000 0000
R 2 0000 4000
W f 1234 0000
R f 0000 0000
W 4 3ffe 0000
R 4 0000 fffe
A 0 2000 3fff
A 0 1234 0dcb
W 2 7fff 0000
R 2 0000 7fff
A 1 1234 1b93
A 1 0000 1fff
A 1 3fff 2000
A 1 2000 3ffc
W 9 0100 0000
D 0 0000 1eff
W 6 2000 0000
W 8 0064 0000
W a 3000 0000
R a 0000 f000
D 1 0000 279b
W 0 0001 0000
A 0 1555 0100
A 1 2aaa 30c6
P 0 0000 0000
W c 00ff 0000
P 1 0000 00ff
W d 01ab 0000
R d 0000 00ab
P 2 0000 00ab

//--- compile.f
source/rp_pkg.sv
source/rp_cfg_if.sv
source/rp_regs.sv
source/rp_linear.sv
source/rp_pdm.sv
source/rp_analog_top.sv
bench/rp_asserts.sv
bench/rp_tb.sv

//--- run.sh
#!/usr/bin/env bash
# verilator build of rp_tb; passes only when the run prints the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module rp_tb -o rp_sim &&
  ./obj_dir/rp_sim | tee /dev/stderr | grep -F "TEST PASS" > /dev/null &&
  echo "simulation passed" || { echo "simulation failed"; exit 1; }
